// ==== hdl/branchUnit.sv ====
//------------------------------------------------------------
// Branch unit
// Resolves branch conditions, drives the next fetch address
// and carries the PC pipeline, link PC and skip flag
//------------------------------------------------------------
`timescale 1ns/1ns
`include "frontEnd_cfg.svh"

module branchUnit
   import isaPkg::*, pipePkg::*;
(
   input  logic              gclk,
   input  logic              grst,
   input  logic              en,
   input  logic              advance,
   input  branchCtlT         ctl,
   input  logic [31:0]       regA,
   input  logic [31:0]       result,
   output logic [31:0]       fetchAddr,
   output logic [`FE_AW-1:0] pcDecode,
   output logic [`FE_AW-1:0] pcOut,
   output logic [`FE_AW-1:0] pcLink,
   output logic              skip
);

   logic              isZero;
   logic              isNeg;
   logic              condMet;
   logic              taken;
   logic              takenQ;
   logic              skipNext;
   logic [`FE_AW-1:0] fetchQ;
   logic [`FE_AW-1:0] nextAddr;

   // Condition flags of register A
   assign isZero = (regA == 32'd0);
   assign isNeg  = regA[31];

   always_comb begin
      case (ctl.cond)
         COND_EQ: condMet = isZero;
         COND_NE: condMet = ~isZero;
         COND_LT: condMet = isNeg;
         COND_LE: condMet = isNeg | isZero;
         COND_GT: condMet = ~(isNeg | isZero);
         COND_GE: condMet = ~isNeg;
         // Codes 6 and 7
         default: condMet = 1'b0;
      endcase
   end

   // BRU and RTD always redirect
   assign taken = ctl.isBru | ctl.isRtd | (ctl.isBcc & condMet);

   // Cancel slot after an undelayed branch, and one more after any taken
   assign skipNext = (taken & ~ctl.delayed) | takenQ;

   // Redirect from the adder, else step by advance
   assign nextAddr = taken ? result[31:2]
                           : fetchQ + {{(`FE_AW-1){1'b0}}, advance};

   assign fetchAddr = {nextAddr, 2'b00};

   // fetchQ follows ROM latency, pcDecode lines up with decode
   always_ff @(posedge gclk) begin
      if (grst) begin
         fetchQ   <= `FE_RESET_PC;
         pcDecode <= `FE_RESET_PC;
         pcOut    <= `FE_RESET_PC;
         pcLink   <= `FE_RESET_PC;
         takenQ   <= 1'b0;
         skip     <= 1'b0;
      end else if (en) begin
         fetchQ   <= nextAddr;
         pcDecode <= fetchQ;
         pcOut    <= pcDecode;
         // Link is the PC one instruction behind
         pcLink   <= pcOut;
         takenQ   <= taken;
         skip     <= skipNext;
      end
   end

endmodule

// ==== hdl/frontEnd.sv ====
//------------------------------------------------------------
// Instruction front end top
// Decode, register read, target add and branch resolve
// around an external instruction ROM
//------------------------------------------------------------
`timescale 1ns/1ns
`include "frontEnd_cfg.svh"

module frontEnd
   import isaPkg::*, pipePkg::*;
(
   input  logic              gclk,
   input  logic              grst,
   input  logic              en,
   input  logic              advance,
   output logic [31:0]       fetchAddr,
   input  instWordU          instWord,
   input  logic              wrEn,
   input  logic [4:0]        wrAddr,
   input  logic [31:0]       wrData,
   output logic [`FE_AW-1:0] pcOut,
   output logic [`FE_AW-1:0] pcLink,
   output logic              skip
);

   decodedT           dec;
   branchCtlT         ctl;
   logic [31:0]       regA;
   logic [31:0]       regB;
   logic [31:0]       result;
   logic [`FE_AW-1:0] pcDecode;

   // Word from ROM, PC from the branch unit pipeline
   instDecode uDecode (
      .gclk     (gclk),
      .grst     (grst),
      .en       (en),
      .instWord (instWord),
      .pc       (pcDecode),
      .dec      (dec),
      .ctl      (ctl)
   );

   // Preloaded from outside through the write port
   regFile uRegs (
      .gclk    (gclk),
      .grst    (grst),
      .wrEn    (wrEn),
      .wrAddr  (wrAddr),
      .wrData  (wrData),
      .rdAddrA (dec.ra),
      .rdAddrB (dec.rb),
      .rdDataA (regA),
      .rdDataB (regB)
   );

   targetAdder uAdder (
      .dec    (dec),
      .regA   (regA),
      .regB   (regB),
      .result (result)
   );

   branchUnit uBranch (
      .gclk      (gclk),
      .grst      (grst),
      .en        (en),
      .advance   (advance),
      .ctl       (ctl),
      .regA      (regA),
      .result    (result),
      .fetchAddr (fetchAddr),
      .pcDecode  (pcDecode),
      .pcOut     (pcOut),
      .pcLink    (pcLink),
      .skip      (skip)
   );

endmodule

// ==== hdl/instDecode.sv ====
//------------------------------------------------------------
// Instruction decode
// Registers the fetched word and splits it into a decoded
// record and branch flags, handles the IMM prefix
//------------------------------------------------------------
`timescale 1ns/1ns
`include "frontEnd_cfg.svh"

module instDecode
   import isaPkg::*, pipePkg::*;
(
   input  logic              gclk,
   input  logic              grst,
   input  logic              en,
   input  instWordU          instWord,
   input  logic [`FE_AW-1:0] pc,
   output decodedT           dec,
   output branchCtlT         ctl
);

   instWordU    word;
   logic        immHiValid;
   logic [15:0] immHi;
   opcodeT      opc;
   logic [4:0]  rd;
   logic [4:0]  ra;
   logic        isBru;
   logic        isBcc;
   logic        isRtd;

   // Decode register, cleared word is not a branch
   always_ff @(posedge gclk) begin
      if (grst) begin
         word       <= '0;
         immHiValid <= 1'b0;
      end else if (en) begin
         word       <= instWord;
         immHiValid <= (word.immForm.opcode == OP_IMM);
      end
   end

   // Upper immediate half, only read when immHiValid
   always_ff @(posedge gclk) begin
      if (en) begin
         immHi <= word.immForm.imm;
      end
   end

   // Shared fields sit at the same bits in both views
   assign opc = word.regForm.opcode;
   assign rd  = word.regForm.rd;
   assign ra  = word.regForm.ra;

   assign isBru = (opc == OP_BRU) || (opc == OP_BRUI);
   assign isBcc = (opc == OP_BCC) || (opc == OP_BCCI);
   assign isRtd = (opc == OP_RTD);

   always_comb begin
      dec.opcode = opc;
      dec.rd     = rd;
      dec.ra     = ra;
      dec.pc     = pc;
      // Opcode bit 3 picks the immediate view
      if (opc[3]) begin
         dec.useImm = 1'b1;
         dec.rb     = 5'd0;
         if (immHiValid) begin
            dec.imm = {immHi, word.immForm.imm};
         end else begin
            dec.imm = {{16{word.immForm.imm[15]}}, word.immForm.imm};
         end
      end else begin
         dec.useImm = 1'b0;
         dec.rb     = word.regForm.rb;
         dec.imm    = 32'd0;
      end
      // BCC always PC relative, BRU absolute when ra[3] set
      dec.pcRelative = isBcc | (isBru & ~ra[3]);
   end

   // Delay bit sits in ra for BRU, rd for BCC
   always_comb begin
      ctl.isBru   = isBru;
      ctl.isBcc   = isBcc;
      ctl.isRtd   = isRtd;
      ctl.cond    = condT'(rd[2:0]);
      ctl.delayed = (isBru & ra[4]) | (isBcc & rd[4]) | isRtd;
   end

endmodule

// ==== hdl/isaPkg.sv ====
//------------------------------------------------------------
// Instruction set definitions
// Major opcodes, branch condition codes and the two views
// of the 32-bit instruction word
//------------------------------------------------------------
package isaPkg;

   // Major opcode, top six bits of every instruction
   typedef logic [5:0] opcodeT;

   // Unconditional branch, register and immediate form
   localparam opcodeT OP_BRU  = 6'o46;
   localparam opcodeT OP_BRUI = 6'o56;
   // Conditional branch, register and immediate form
   localparam opcodeT OP_BCC  = 6'o47;
   localparam opcodeT OP_BCCI = 6'o57;
   // Return from subroutine, always delayed
   localparam opcodeT OP_RTD  = 6'o55;
   // Immediate prefix, supplies upper half of next immediate
   localparam opcodeT OP_IMM  = 6'o54;

   // Branch condition, carried in rd[2:0] of BCC
   // Codes 6 and 7 are never taken
   typedef enum logic [2:0] {
      COND_EQ = 3'd0,
      COND_NE = 3'd1,
      COND_LT = 3'd2,
      COND_LE = 3'd3,
      COND_GT = 3'd4,
      COND_GE = 3'd5
   } condT;

   // Register form, opcode bit 3 clear
   typedef struct packed {
      opcodeT      opcode;
      logic [4:0]  rd;
      logic [4:0]  ra;
      logic [4:0]  rb;
      logic [10:0] func;
   } regFormT;

   // Immediate form, opcode bit 3 set
   typedef struct packed {
      opcodeT      opcode;
      logic [4:0]  rd;
      logic [4:0]  ra;
      logic [15:0] imm;
   } immFormT;

   // Same 32 bits, opcode/rd/ra line up in both views
   typedef union packed {
      regFormT regForm;
      immFormT immForm;
   } instWordU;

endpackage

// ==== hdl/pipePkg.sv ====
//------------------------------------------------------------
// Pipeline records
// Decoded instruction and branch flags passed from decode
// to the target adder and branch unit
//------------------------------------------------------------
`include "frontEnd_cfg.svh"

package pipePkg;
   import isaPkg::*;

   // Decoded instruction as seen by execute
   typedef struct packed {
      opcodeT            opcode;
      logic [4:0]        rd;
      logic [4:0]        ra;
      logic [4:0]        rb;
      logic [31:0]       imm;        // sign extended, or prefixed by IMM
      logic              useImm;     // operand B from imm
      logic              pcRelative; // operand A from pc
      logic [`FE_AW-1:0] pc;
   } decodedT;

   // Branch classification of the decoded instruction
   typedef struct packed {
      logic isBru;
      logic isBcc;
      logic isRtd;
      condT cond;
      logic delayed;
   } branchCtlT;

endpackage

// ==== hdl/regFile.sv ====
//------------------------------------------------------------
// Register file
// 32 x 32-bit, one synchronous write port and two
// asynchronous read ports, r0 always reads zero
//------------------------------------------------------------
`timescale 1ns/1ns

module regFile (
   input  logic        gclk,
   input  logic        grst,
   input  logic        wrEn,
   input  logic [4:0]  wrAddr,
   input  logic [31:0] wrData,
   input  logic [4:0]  rdAddrA,
   input  logic [4:0]  rdAddrB,
   output logic [31:0] rdDataA,
   output logic [31:0] rdDataB
);

   logic [31:0] regs [32];

   // Writes to r0 are dropped
   always_ff @(posedge gclk) begin
      if (grst) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (wrEn && (wrAddr != 5'd0)) begin
         regs[wrAddr] <= wrData;
      end
   end

   // Read port A, branch condition and target base
   assign rdDataA = (rdAddrA == 5'd0) ? 32'd0 : regs[rdAddrA];

   // Read port B, target offset in register form
   assign rdDataB = (rdAddrB == 5'd0) ? 32'd0 : regs[rdAddrB];

endmodule

// ==== hdl/targetAdder.sv ====
//------------------------------------------------------------
// Branch target adder
// PC or register A plus immediate or register B
//------------------------------------------------------------
`timescale 1ns/1ns

module targetAdder
   import pipePkg::*;
(
   input  decodedT     dec,
   input  logic [31:0] regA,
   input  logic [31:0] regB,
   output logic [31:0] result
);

   logic [31:0] opA;
   logic [31:0] opB;

   // Operand A, byte address of the instruction for relative branches
   assign opA = dec.pcRelative ? {dec.pc, 2'b00} : regA;

   // Operand B
   assign opB = dec.useImm ? dec.imm : regB;

   // Only adder in the front end, result bits 1:0 dropped by fetch
   assign result = opA + opB;

endmodule

// ==== include/frontEnd_cfg.svh ====
//------------------------------------------------------------
// Front end configuration
// Word-address width of the PC and the fetch reset vector
//------------------------------------------------------------
`ifndef FRONT_END_CFG_SVH
`define FRONT_END_CFG_SVH

// PC holds word addresses, byte address bits 31 down to 2
`define FE_AW 30

// First word address fetched out of reset
`define FE_RESET_PC 30'd0

`endif

// ==== sim/frontEndTb.sv ====
//------------------------------------------------------------
// Front end testbench
// ROM model, register preload, branch reference model and
// checker on pcOut, pcLink, skip and fetch address
//------------------------------------------------------------
`timescale 1ns/1ns
`include "frontEnd_cfg.svh"

module frontEndTb
   import isaPkg::*;
();

   // Reference outcome of one instruction
   typedef struct packed {
      logic              isBranch;
      logic              taken;
      logic              delayed;
      logic [`FE_AW-1:0] next;
   } expectT;

   logic              gclk;
   logic              grst;
   logic              en;
   logic              advance;
   logic              wrEn;
   logic              skip;
   logic [4:0]        wrAddr;
   logic [31:0]       wrData;
   logic [31:0]       instWord;
   logic [31:0]       fetchAddr;
   logic [31:0]       lastFetch;
   logic [31:0]       cw;
   logic [`FE_AW-1:0] pcOut;
   logic [`FE_AW-1:0] pcLink;
   logic [`FE_AW-1:0] lastPcOut;
   logic [`FE_AW-1:0] pcExp;
   // Reference fetch history, reset vector before the first move
   logic [`FE_AW-1:0] nextQ1 = `FE_RESET_PC;
   logic [`FE_AW-1:0] nextQ2 = `FE_RESET_PC;
   logic [31:0]       rom [256];
   logic [31:0]       regVal [32];
   logic              checking = 1'b0;
   logic              enPrev = 1'b0;
   logic              prevTaken = 1'b0;
   logic              timedOut = 1'b0;
   logic              bad;
   int                seed = 89;
   int                errors = 0;
   int                nBranch = 0;
   expectT            e;

   frontEnd uut (.*);

   initial begin
      gclk = 1'b0;
      forever #4 gclk = ~gclk;
   end

   // ROM answers one cycle after the address
   always @(posedge gclk) begin
      instWord <= rom[fetchAddr[9:2]];
   end

   // Branch rules applied to one word, its PC and its register values
   function automatic expectT expectedNext(input logic [31:0] w, input logic [`FE_AW-1:0] pc,
                                           input logic [`FE_AW-1:0] prevNext,
                                           input logic [31:0] aVal, input logic [31:0] bVal);
      expectT      r;
      logic        bru;
      logic        bcc;
      logic        rtd;
      logic        met;
      logic [31:0] opA;
      logic [31:0] opB;
      logic [31:0] sum;
      bru = (w[31:26] == OP_BRU) || (w[31:26] == OP_BRUI);
      bcc = (w[31:26] == OP_BCC) || (w[31:26] == OP_BCCI);
      rtd = (w[31:26] == OP_RTD);
      // Condition sits in rd[2:0]
      case (w[23:21])
         3'd0: met = (aVal == 32'd0);
         3'd1: met = (aVal != 32'd0);
         3'd2: met = aVal[31];
         3'd3: met = aVal[31] || (aVal == 32'd0);
         3'd4: met = !(aVal[31] || (aVal == 32'd0));
         3'd5: met = !aVal[31];
         default: met = 1'b0;
      endcase
      opA = (bcc || (bru && !w[19])) ? {pc, 2'b00} : aVal;
      opB = w[29] ? {{16{w[15]}}, w[15:0]} : bVal;
      sum = opA + opB;
      r.isBranch = bru || bcc || rtd;
      r.taken    = bru || rtd || (bcc && met);
      r.delayed  = (bru && w[20]) || (bcc && w[25]) || rtd;
      // Not taken, fetch steps one word past the previous instruction's next address
      r.next     = r.taken ? sum[31:2] : prevNext + `FE_AW'd1;
      return r;
   endfunction

   // Checker, runs once per pipeline move at the stable half of the cycle
   always @(negedge gclk) begin
      if (enPrev) begin
         // Expected PC of this move, from two moves back
         pcExp = nextQ2;
         cw    = rom[pcExp[7:0]];
         e     = expectedNext(cw, pcExp, nextQ1, regVal[cw[20:16]], regVal[cw[15:11]]);
         if (checking && (pcExp >= 4) && (pcExp < 148)) begin
            bad = 1'b0;
            if (pcOut != pcExp) begin
               $display("Mismatch at %0t: pcOut %0d, expected %0d", $time, pcOut, pcExp);
               bad = 1'b1;
            end
            if (lastFetch != {e.next, 2'b00}) begin
               $display("Mismatch at %0t: pc %0d fetch %h, expected %h",
                        $time, pcExp, lastFetch, {e.next, 2'b00});
               bad = 1'b1;
            end
            if (pcLink != lastPcOut) begin
               $display("Mismatch at %0t: pc %0d pcLink %0d, expected %0d",
                        $time, pcExp, pcLink, lastPcOut);
               bad = 1'b1;
            end
            if (skip != ((e.taken && !e.delayed) || prevTaken)) begin
               $display("Mismatch at %0t: pc %0d skip %0b, expected %0b", $time, pcExp, skip,
                        (e.taken && !e.delayed) || prevTaken);
               bad = 1'b1;
            end
            if (bad) begin
               errors++;
            end
            if (e.isBranch) begin
               nBranch++;
               $display("Branch at %0d taken %0b delayed %0b: %s",
                        pcExp, e.taken, e.delayed, bad ? "failed" : "ok");
            end
         end
         prevTaken = e.taken;
         lastPcOut = pcExp;
         lastFetch = fetchAddr;
         nextQ2    = nextQ1;
         nextQ1    = e.next;
      end
      enPrev = en;
   end

   // Blocks of four words, branch first, taken target is the next block
   task automatic buildProgram();
      logic [31:0] d;
      int          a;
      for (int i = 0; i < 256; i++) begin
         rom[i] = {6'o00, 26'(i * 733 + 91)};
      end
      for (int b = 0; b < 36; b++) begin
         a = 4 + 4 * b;
         d = $random(seed);
         if (b < 24) begin
            // All eight codes against zero, negative and positive ra
            rom[a] = d[4] ? {OP_BCCI, d[0], 1'b0, 3'(b % 8), d[7:5], 2'(b / 8), 16'd16}
                          : {OP_BCC, d[0], 1'b0, 3'(b % 8), d[7:5], 2'(b / 8),
                             d[10:8], 2'b11, 11'd0};
         end else begin
            case (b % 4)
               0: rom[a] = {OP_BRUI, 5'd0, d[0], 1'b0, d[3:1], 16'd16};
               // Absolute, base register reads zero
               1: rom[a] = {OP_BRUI, 5'd0, d[0], 4'b1000, 16'(4 * (a + 4))};
               2: rom[a] = {OP_BRU, 5'd0, d[0], 1'b0, d[3:1], d[10:8], 2'b11, 11'd0};
               default: rom[a] = {OP_RTD, 5'd0, d[3:1], 2'b00, 16'(4 * (a + 4))};
            endcase
         end
      end
   endtask

   task automatic waitPc(input logic [`FE_AW-1:0] target);
      int n = 0;
      while ((pcOut != target) && (n < 400)) begin
         @(negedge gclk);
         n++;
      end
      if (pcOut != target) begin
         $display("Timeout: pcOut never reached %0d", target);
         timedOut = 1'b1;
      end
   endtask

   // en low for four cycles, outputs must not move
   task automatic holdCheck();
      logic [`FE_AW-1:0] p;
      logic [`FE_AW-1:0] l;
      logic              s;
      int                fails = 0;
      @(posedge gclk);
      en <= 1'b0;
      @(negedge gclk);
      p = pcOut;
      l = pcLink;
      s = skip;
      repeat (4) begin
         @(negedge gclk);
         if ({pcOut, pcLink, skip} != {p, l, s}) begin
            $display("Mismatch at %0t: outputs moved while en was low", $time);
            fails++;
         end
      end
      @(posedge gclk);
      en <= 1'b1;
      errors += fails;
      $display("Hold test: %s", (fails == 0) ? "ok" : "failed");
   endtask

   // advance low, fetch address must repeat
   task automatic advanceCheck();
      logic [31:0] f;
      int          fails = 0;
      @(posedge gclk);
      advance <= 1'b0;
      @(negedge gclk);
      f = fetchAddr;
      repeat (4) begin
         @(negedge gclk);
         if (fetchAddr != f) begin
            $display("Mismatch at %0t: fetch %h moved, held at %h", $time, fetchAddr, f);
            fails++;
         end
      end
      @(posedge gclk);
      advance <= 1'b1;
      errors += fails;
      $display("Advance test: %s", (fails == 0) ? "ok" : "failed");
   endtask

   initial begin
      grst     <= 1'b1;
      en       <= 1'b0;
      advance  <= 1'b1;
      wrEn     <= 1'b0;
      wrAddr   <= 5'd0;
      wrData   <= 32'd0;
      instWord <= 32'd0;
      // Register classes by index, zero, negative, positive, offset 16
      for (int i = 0; i < 32; i++) begin
         case (i % 4)
            0: regVal[i] = 32'd0;
            1: regVal[i] = $random(seed) | 32'h8000_0000;
            2: regVal[i] = ($random(seed) & 32'h7fff_ffff) | 32'd1;
            default: regVal[i] = 32'd16;
         endcase
      end
      buildProgram();
      repeat (10) @(posedge gclk);
      grst <= 1'b0;
      // Preload with the pipeline frozen
      for (int i = 1; i < 32; i++) begin
         @(posedge gclk);
         wrEn   <= 1'b1;
         wrAddr <= 5'(i);
         wrData <= regVal[i];
      end
      @(posedge gclk);
      wrEn     <= 1'b0;
      en       <= 1'b1;
      checking <= 1'b1;
      waitPc(`FE_AW'd60);
      if (!timedOut) begin
         holdCheck();
         waitPc(`FE_AW'd150);
      end
      checking <= 1'b0;
      if (!timedOut) begin
         advanceCheck();
      end
      errors += uut.uBranch.uSva.failCount;
      if (nBranch != 36) begin
         $display("Only %0d of 36 branch tests ran", nBranch);
      end
      $display("Branch tests %0d, failures %0d", nBranch, errors);
      if ((errors == 0) && !timedOut && (nBranch == 36)) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

// ==== sim/frontEnd_sva.sv ====
//------------------------------------------------------------
// Branch unit assertions
// Reset, hold and reset-vector fetch checks bound into branchUnit
//------------------------------------------------------------
`timescale 1ns/1ns
`include "frontEnd_cfg.svh"

module branchUnitSva (
   input logic              gclk,
   input logic              grst,
   input logic              en,
   input logic              advance,
   input logic [31:0]       fetchAddr,
   input logic [`FE_AW-1:0] pcOut,
   input logic [`FE_AW-1:0] pcLink,
   input logic              skip
);

   // Failures seen, summed into the testbench count
   int failCount = 0;

   // Reset clears skip by the next edge
   skipReset: assert property (@(posedge gclk) grst |=> !skip)
      else begin
         $error("skip still high after a reset cycle");
         failCount++;
      end

   // en low freezes every output register
   holdOnStall: assert property (@(posedge gclk) disable iff (grst)
      !en |=> $stable(pcOut) && $stable(pcLink) && $stable(skip))
      else begin
         $error("branch unit registers changed while en was low");
         failCount++;
      end

   // Out of reset no branch is decoded, fetch steps from the reset vector by advance
   fetchFromReset: assert property (@(posedge gclk)
      grst |=> fetchAddr == {`FE_RESET_PC + `FE_AW'(advance), 2'b00})
      else begin
         $error("fetchAddr not stepping from the reset vector after reset");
         failCount++;
      end

endmodule

bind branchUnit branchUnitSva uSva (.*);

// ==== src.f ====
+incdir+include
hdl/isaPkg.sv
hdl/pipePkg.sv
hdl/regFile.sv
hdl/instDecode.sv
hdl/targetAdder.sv
hdl/branchUnit.sv
hdl/frontEnd.sv
sim/frontEnd_sva.sv
sim/frontEndTb.sv
